/* cart_rom.f */
+incdir+rtl
rtl/cart_rom_pkg.sv
rtl/cart_rom_ifs.sv
rtl/snes_bus_front.sv
rtl/mcu_request.sv
rtl/rom_arbiter.sv
rtl/cart_rom_top.sv
tb/tb_cart_rom.sv

/* Bender.yml */
package:
  name: cart_rom

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cart_rom_pkg.sv
      - rtl/cart_rom_ifs.sv
      - rtl/snes_bus_front.sv
      - rtl/mcu_request.sv
      - rtl/rom_arbiter.sv
      - rtl/cart_rom_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_cart_rom.sv

/* tb/tb_cart_rom.sv */
`timescale 1ns/1ps
`include "cart_rom_config.svh"

module tb_cart_rom;

  localparam logic [15:0] rom_fill = 16'h5a3c;
  localparam int cycle_len = 24;  // CLK2 cycles per SNES bus cycle
  localparam int run_cycles = `SNES_DEAD_TIMEOUT + 4 * 8 * cycle_len + 16 * 40 + 1000;
  localparam int timeout_cycles = 2 * run_cycles;
  localparam int we_low_len = `ROM_CYCLE_LEN + 1;

  logic                        CLK2;
  logic                        reset;
  logic [`SNES_ADDR_W-1:0]     snes_addr_in;
  logic                        snes_read_in;
  logic                        snes_cpu_clk_in;
  logic                        snes_romsel_in;
  logic [`BYTE_W-1:0]          snes_data_out;
  logic                        snes_data_oe;
  logic                        hirom;
  logic [`SNES_ADDR_W-1:0]     rom_mask;
  logic                        mcu_rrq;
  logic                        mcu_wrq;
  logic [`SNES_ADDR_W-1:0]     mcu_addr;
  logic [`BYTE_W-1:0]          mcu_data_out;
  logic                        mcu_rdy;
  logic [`BYTE_W-1:0]          mcu_data_in;
  logic [`ROM_DATA_W-1:0]      rom_data_in;
  logic [`ROM_DATA_W-1:0]      rom_data_out;
  logic                        rom_data_oe;
  logic [`ROM_WORD_ADDR_W-1:0] rom_addr;
  logic                        rom_we;
  logic                        rom_bhe;
  logic                        rom_ble;

  logic [15:0] rom_mem [logic [22:0]];  // Only written words live here
  logic [22:0] wr_word;
  logic [15:0] wr_val;
  logic [15:0] merge_w;
  logic        wr_lo;
  logic        wr_hi;
  logic        wr_seen = 1'b0;
  int          mem_wr_cnt = 0;
  integer      seed;
  int          cycle_cnt = 0;
  int          we_low_cnt = 0;
  string       test_name = "none";
  logic        mcu_rd_busy = 1'b0;
  logic        cur_lo_sel = 1'b0;
  logic        snes_chk_en = 1'b0;
  logic [22:0] exp_snes_word = '0;
  logic [23:0] addr;
  logic [23:0] rd_addr_a;
  logic [23:0] rd_addr_b;
  logic [7:0]  data;

  cart_rom_top u_dut (.*);

  initial begin
    CLK2 = 1'b0;
    forever #2 CLK2 = ~CLK2;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [23:0] expected,
                             input logic [23:0] actual);
    assert (actual === expected)
      else report_fail($sformatf("CHECK FAILED test=%s check=%s expected=%0h actual=%0h",
                                 test_name, name, expected, actual));
  endtask

  ////////////////////////////////////////
  // PSRAM model
  ////////////////////////////////////////

  function automatic logic [15:0] rom_word(input logic [22:0] a);
    if (rom_mem.exists(a)) return rom_mem[a];
    return a[15:0] ^ rom_fill ^ {a[22:16], 9'h000};  // Upper bits folded in
  endfunction

  function automatic logic [7:0] rom_byte(input logic [23:0] byte_addr);
    logic [15:0] w;
    w = rom_word(byte_addr[23:1]);
    return byte_addr[0] ? w[7:0] : w[15:8];  // Bit 0 set picks the low lane
  endfunction

  function automatic logic [23:0] snes_to_rom(input logic [23:0] a, input logic hi,
                                              input logic [23:0] mask);
    logic [23:0] raw;
    if (hi) raw = a & 24'h3f_ffff;  // Banks mirror every 4 MB
    else raw = ({17'h0, a[22:16]} << 15) | {9'h0, a[14:0]};  // 32 KB per bank
    return raw & mask;
  endfunction

  always @(rom_addr or mem_wr_cnt) rom_data_in = rom_word(rom_addr);

  always @(posedge CLK2) begin
    if (rom_we === 1'b0) begin  // Last write cycle wins
      wr_word = rom_addr;
      wr_val  = rom_data_oe ? rom_data_out : 'x;  // Bus floats without OE
      wr_lo   = ~rom_ble;
      wr_hi   = ~rom_bhe;
      wr_seen = 1'b1;
    end
  end

  always @(posedge rom_we) begin
    if (wr_seen) begin
      merge_w = rom_word(wr_word);
      if (wr_lo) merge_w[7:0] = wr_val[7:0];
      if (wr_hi) merge_w[15:8] = wr_val[15:8];
      rom_mem[wr_word] = merge_w;
      wr_seen = 1'b0;
      mem_wr_cnt++;
    end
  end

  ////////////////////////////////////////
  // Bus checks and timeout
  ////////////////////////////////////////

  always @(posedge CLK2) begin
    if (reset) we_low_cnt = 0;
    else if (rom_we === 1'b0) we_low_cnt++;
    else if (we_low_cnt != 0) begin
      check_value("we_len", we_low_len, we_low_cnt);
      we_low_cnt = 0;
    end
  end

  assert property (@(posedge CLK2) disable iff (reset) mcu_rd_busy |-> rom_we)
    else report_fail($sformatf("CHECK FAILED test=%s check=we_in_read expected=1 actual=0",
                               test_name));

  assert property (@(posedge CLK2) disable iff (reset)
    rom_data_oe |-> (rom_bhe == cur_lo_sel) && (rom_ble == !cur_lo_sel))
    else report_fail($sformatf("CHECK FAILED test=%s check=lanes expected=%b actual=%b%b",
                               test_name, {cur_lo_sel, !cur_lo_sel}, rom_bhe, rom_ble));

  assert property (@(posedge CLK2) disable iff (reset) snes_chk_en |-> rom_addr == exp_snes_word)
    else report_fail($sformatf("CHECK FAILED test=%s check=rom_addr expected=%0h actual=%0h",
                               test_name, exp_snes_word, rom_addr));

  always @(posedge CLK2) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles)
      report_fail($sformatf("Timeout, run still going after %0d cycles", timeout_cycles));
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic mcu_access(input logic wr, input logic [23:0] a, input logic [7:0] d);
    @(posedge CLK2);
    mcu_addr     <= a;
    mcu_data_out <= d;
    mcu_rrq      <= ~wr;
    mcu_wrq      <= wr;
    cur_lo_sel   <= a[0];
    mcu_rd_busy  <= ~wr;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    check_value("rdy_fall", 0, mcu_rdy);
    while (mcu_rdy !== 1'b1) @(negedge CLK2);  // Timeout guards this wait
    mcu_rd_busy <= 1'b0;
  endtask

  // One SNES CPU cycle, clock low then high, read strobe late in the cycle
  task automatic snes_cycle(input logic [23:0] a, input logic rom);
    logic [23:0] exp_rom;
    int          i;
    for (i = 0; i < cycle_len; i++) begin
      @(posedge CLK2);
      case (i)
        0: begin
          exp_rom = snes_to_rom(a, hirom, rom_mask);
          snes_cpu_clk_in <= 1'b0;
          snes_addr_in    <= a;
          snes_romsel_in  <= ~rom;
          snes_read_in    <= 1'b1;
          snes_chk_en     <= 1'b0;
          exp_snes_word   <= exp_rom[23:1];
        end
        8: snes_cpu_clk_in <= 1'b1;
        18: if (rom) begin
          snes_read_in <= 1'b0;
          snes_chk_en  <= 1'b1;
        end
        22: if (rom) begin
          @(negedge CLK2);
          check_value("snes_oe", 1, snes_data_oe);
          check_value("snes_data", rom_byte(exp_rom), snes_data_out);
        end
        cycle_len - 1: snes_chk_en <= 1'b0;
        default: ;
      endcase
    end
  endtask

  task automatic dead_rw_pair();
    addr = $random(seed);
    data = $random(seed);
    mcu_access(1'b1, addr, data);
    check_value("model_byte", data, rom_byte(addr));
    mcu_access(1'b0, addr, 8'h00);
    check_value("mcu_data_in", data, mcu_data_in);
  endtask

  initial begin
    seed            = 69;
    reset           = 1'b1;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_cpu_clk_in = 1'b0;
    snes_romsel_in  = 1'b1;
    hirom           = 1'b0;
    rom_mask        = '1;
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mcu_addr        = '0;
    mcu_data_out    = '0;
    rom_data_in     = '0;
    repeat (3) @(posedge CLK2);
    reset <= 1'b0;
    @(negedge CLK2);
    test_name = "reset";
    check_value("mcu_rdy", 1, mcu_rdy);
    check_value("rom_we", 1, rom_we);
    check_value("snes_data_oe", 0, snes_data_oe);
    check_value("rom_data_oe", 0, rom_data_oe);

    test_name = "dead_mcu";
    for (int k = 0; k < 4; k++) begin
      dead_rw_pair();
    end

    test_name = "lorom_read";
    @(posedge CLK2);
    hirom    <= 1'b0;
    rom_mask <= 24'h0f_ffff;
    repeat (8) begin
      addr = $random(seed);
      addr[15] = 1'b1;  // ROM half of the bank
      snes_cycle(addr, 1'b1);
    end

    test_name = "hirom_read";
    @(posedge CLK2);
    hirom    <= 1'b1;
    rom_mask <= 24'h1f_ffff;
    repeat (8) begin
      addr = $random(seed);
      addr[23:22] = 2'b11;
      snes_cycle(addr, 1'b1);
    end

    test_name = "alive_mcu";
    @(posedge CLK2);
    hirom    <= 1'b0;
    rom_mask <= 24'h0f_ffff;
    rd_addr_a = $random(seed);
    rd_addr_b = $random(seed);
    fork
      begin
        for (int k = 0; k < 8; k++) begin
          addr = $random(seed);
          addr[15] = 1'b1;
          snes_cycle(addr, k != 2);  // Cycle 2 leaves ROM alone
        end
      end
      begin
        repeat (30) @(posedge CLK2);
        mcu_access(1'b0, rd_addr_a, 8'h00);
        check_value("mcu_data_in", rom_byte(rd_addr_a), mcu_data_in);
        repeat (20) @(posedge CLK2);
        mcu_access(1'b0, rd_addr_b, 8'h00);
        check_value("mcu_data_in", rom_byte(rd_addr_b), mcu_data_in);
      end
    join

    // Stop the CPU clock and let the console die again
    test_name = "dead_again";
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    snes_read_in    <= 1'b1;
    snes_romsel_in  <= 1'b1;
    snes_chk_en     <= 1'b0;
    repeat (`SNES_DEAD_TIMEOUT + 16) @(posedge CLK2);
    dead_rw_pair();

    $display("Simulation passed");
    $finish;
  end

endmodule

/* rtl/cart_rom_top.sv */
`timescale 1ns/1ps
`include "cart_rom_config.svh"

module cart_rom_top (
  input  logic                        CLK2,
  input  logic                        reset,
  // SNES bus
  input  logic [`SNES_ADDR_W-1:0]     snes_addr_in,
  input  logic                        snes_read_in,
  input  logic                        snes_cpu_clk_in,
  input  logic                        snes_romsel_in,
  output logic [`BYTE_W-1:0]          snes_data_out,
  output logic                        snes_data_oe,
  // Mapper setup
  input  logic                        hirom,
  input  logic [`SNES_ADDR_W-1:0]     rom_mask,
  // MCU
  input  logic                        mcu_rrq,
  input  logic                        mcu_wrq,
  input  logic [`SNES_ADDR_W-1:0]     mcu_addr,
  input  logic [`BYTE_W-1:0]          mcu_data_out,
  output logic                        mcu_rdy,
  output logic [`BYTE_W-1:0]          mcu_data_in,
  // PSRAM
  input  logic [`ROM_DATA_W-1:0]      rom_data_in,
  output logic [`ROM_DATA_W-1:0]      rom_data_out,
  output logic                        rom_data_oe,
  output logic [`ROM_WORD_ADDR_W-1:0] rom_addr,
  output logic                        rom_we,
  output logic                        rom_bhe,
  output logic                        rom_ble
);

  snes_bus_if bus_if ();
  mcu_rq_if   rq_if ();

  snes_bus_front u_front (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_romsel_in  (snes_romsel_in),
    .hirom           (hirom),
    .rom_mask        (rom_mask),
    .bus             (bus_if.front)
  );

  mcu_request u_request (
    .CLK2         (CLK2),
    .reset        (reset),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .mcu_data_out (mcu_data_out),
    .mcu_rdy      (mcu_rdy),
    .rq           (rq_if.req)
  );

  rom_arbiter u_arbiter (
    .CLK2          (CLK2),
    .reset         (reset),
    .bus           (bus_if.arb),
    .rq            (rq_if.arb),
    .rom_data_in   (rom_data_in),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_addr      (rom_addr),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .mcu_data_in   (mcu_data_in),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

/* rtl/rom_arbiter.sv */
`timescale 1ns/1ps
`include "cart_rom_config.svh"

module rom_arbiter import cart_rom_pkg::*; (
  input  logic                        CLK2,
  input  logic                        reset,
  snes_bus_if.arb                     bus,
  mcu_rq_if.arb                       rq,
  input  logic [`ROM_DATA_W-1:0]      rom_data_in,
  output logic [`ROM_DATA_W-1:0]      rom_data_out,
  output logic                        rom_data_oe,
  output logic [`ROM_WORD_ADDR_W-1:0] rom_addr,
  output logic                        rom_we,
  output logic                        rom_bhe,
  output logic                        rom_ble,
  output logic [`BYTE_W-1:0]          mcu_data_in,
  output logic [`BYTE_W-1:0]          snes_data_out,
  output logic                        snes_data_oe
);

  localparam int dly_w = $clog2(`ROM_CYCLE_LEN + 1);

  arb_state_e         state;
  logic [dly_w-1:0]   mem_dly;
  logic               free_strobe;
  logic               free_slot;
  logic               dead_q;
  logic               mcu_hit;
  rom_addr_u          sel_addr;
  logic [`BYTE_W-1:0] rd_lane;

  ////////////////////////////////////////
  // Free slot detection
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
      dead_q      <= 1'b1;
    end else begin
      free_strobe <= bus.cycle_start & ~bus.rom_hit;  // Cycle without ROM access
      dead_q      <= bus.snes_dead;
    end
  end

  assign free_slot = bus.cycle_end | free_strobe;

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state   <= idle;
      mem_dly <= '0;
    end else if (dead_q & ~bus.snes_dead) begin
      state <= idle;  // Console woke up, redo the access in a free slot
    end else begin
      case (state)
        idle: begin
          if (free_slot | bus.snes_dead) begin
            if (rq.rd_pend) begin
              state   <= mcu_rd_addr;
              mem_dly <= dly_w'(`ROM_CYCLE_LEN);
            end else if (rq.wr_pend) begin
              state   <= mcu_wr_addr;
              mem_dly <= dly_w'(`ROM_CYCLE_LEN);
            end
          end
        end
        mcu_rd_addr: begin
          mem_dly <= mem_dly - 1'b1;
          if (mem_dly == '0) state <= mcu_rd_end;
        end
        mcu_wr_addr: begin
          mem_dly <= mem_dly - 1'b1;
          if (mem_dly == '0) state <= mcu_wr_end;
        end
        mcu_rd_end, mcu_wr_end: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  assign rq.done = (state == mcu_rd_end) || (state == mcu_wr_end);

  ////////////////////////////////////////
  // PSRAM and SNES data path
  ////////////////////////////////////////

  assign mcu_hit  = (state == mcu_rd_addr) || (state == mcu_wr_addr);
  assign sel_addr = mcu_hit ? rq.addr : bus.map_addr;

  assign rom_addr = sel_addr.w.word_addr;
  assign rom_bhe  = sel_addr.w.lo_sel;
  assign rom_ble  = ~sel_addr.w.lo_sel;
  assign rd_lane  = sel_addr.w.lo_sel ? rom_data_in[7:0] : rom_data_in[15:8];

  // Last sample before the end state is the one handed to the MCU
  always_ff @(posedge CLK2) begin
    if (state == mcu_rd_addr) begin
      mcu_data_in <= rd_lane;
    end
  end

  assign rom_we       = (state != mcu_wr_addr);
  assign rom_data_oe  = (state == mcu_wr_addr);
  assign rom_data_out = sel_addr.w.lo_sel ? {{`BYTE_W{1'b0}}, rq.wr_data}
                                          : {rq.wr_data, {`BYTE_W{1'b0}}};

  assign snes_data_out = rd_lane;
  assign snes_data_oe  = bus.rom_hit & bus.rd_active;

  // PSRAM write only ever on behalf of a pending MCU write
  assert property (@(posedge CLK2) disable iff (reset) !rom_we |-> rq.wr_pend);

endmodule

/* rtl/mcu_request.sv */
`timescale 1ns/1ps
`include "cart_rom_config.svh"

module mcu_request import cart_rom_pkg::*; (
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  logic [`SNES_ADDR_W-1:0] mcu_addr,
  input  logic [`BYTE_W-1:0]      mcu_data_out,
  output logic                    mcu_rdy,
  mcu_rq_if.req                   rq
);

  logic               rd_pend;
  logic               wr_pend;
  logic               rrq_ok;
  logic               wrq_ok;
  rom_addr_u          addr_q;
  logic [`BYTE_W-1:0] wr_data_q;

  // Busy MCU port drops new pulses
  assign rrq_ok = mcu_rrq & mcu_rdy;
  assign wrq_ok = mcu_wrq & mcu_rdy;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (rrq_ok) begin  // Read wins a tie
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (wrq_ok) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (rq.done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (rrq_ok | wrq_ok) begin
      addr_q.byte_addr <= mcu_addr;
      wr_data_q        <= mcu_data_out;
    end
  end

  assign rq.rd_pend = rd_pend;
  assign rq.wr_pend = wr_pend;
  assign rq.addr    = addr_q;
  assign rq.wr_data = wr_data_q;

  // MCU must hold off until the previous access has finished
  assert property (@(posedge CLK2) disable iff (reset) !mcu_rdy |-> !(mcu_rrq || mcu_wrq));

endmodule

/* rtl/snes_bus_front.sv */
`timescale 1ns/1ps
`include "cart_rom_config.svh"

module snes_bus_front import cart_rom_pkg::*; (
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic [`SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                    snes_read_in,
  input  logic                    snes_cpu_clk_in,
  input  logic                    snes_romsel_in,
  input  logic                    hirom,
  input  logic [`SNES_ADDR_W-1:0] rom_mask,
  snes_bus_if.front               bus
);

  localparam int dead_cnt_w = $clog2(`SNES_DEAD_TIMEOUT + 1);
  localparam logic [dead_cnt_w-1:0] dead_limit = dead_cnt_w'(`SNES_DEAD_TIMEOUT - 1);

  // Edge patterns over the OR/AND of two neighbouring samples
  localparam logic [`SYNC_DEPTH-3:0] cycle_start_pat = {{(`SYNC_DEPTH - 4){1'b0}}, 2'b11};
  localparam logic [`SYNC_DEPTH-3:0] cycle_end_pat   = {3'b111, {(`SYNC_DEPTH - 5){1'b0}}};

  logic [`SYNC_DEPTH-1:0]  read_r;
  logic [`SYNC_DEPTH-1:0]  cpu_clk_r;
  logic [`SYNC_DEPTH-1:0]  romsel_r;
  logic [`SNES_ADDR_W-1:0] addr_r [0:`SYNC_DEPTH-2];

  logic [`SNES_ADDR_W-1:0] snes_addr;
  logic [`SNES_ADDR_W-1:0] raw_addr;
  rom_addr_u               map_addr;
  logic [dead_cnt_w-1:0]   dead_cnt;
  logic                    snes_dead;
  logic                    cycle_start;
  logic                    cycle_end;

  ////////////////////////////////////////
  // Input sampling
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_r    <= '1;  // Strobes idle high
      romsel_r  <= '1;
      cpu_clk_r <= '0;  // Keeps the console dead through reset
    end else begin
      read_r    <= {read_r[`SYNC_DEPTH-2:0], snes_read_in};
      romsel_r  <= {romsel_r[`SYNC_DEPTH-2:0], snes_romsel_in};
      cpu_clk_r <= {cpu_clk_r[`SYNC_DEPTH-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    for (int i = 1; i < `SYNC_DEPTH - 1; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  // Address settles late, use the two oldest copies
  assign snes_addr = addr_r[`SYNC_DEPTH-2] & addr_r[`SYNC_DEPTH-3];

  assign cycle_start = ((cpu_clk_r[`SYNC_DEPTH-1:2] & cpu_clk_r[`SYNC_DEPTH-2:1])
                        == cycle_start_pat);
  assign cycle_end   = ((cpu_clk_r[`SYNC_DEPTH-1:2] | cpu_clk_r[`SYNC_DEPTH-2:1])
                        == cycle_end_pat);

  ////////////////////////////////////////
  // Dead console detection
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else if (cpu_clk_r[1]) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (dead_cnt == dead_limit) begin
      snes_dead <= 1'b1;       // Counter parks here
    end else begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Address mapping
  ////////////////////////////////////////

  always_comb begin
    if (hirom) begin
      raw_addr = {2'b00, snes_addr[21:0]};
    end else begin
      raw_addr = {2'b00, snes_addr[22:16], snes_addr[14:0]};  // A15 dropped
    end
    map_addr.byte_addr = raw_addr & rom_mask;
  end

  assign bus.map_addr    = map_addr;
  assign bus.rom_hit     = ~(romsel_r[2] & romsel_r[1]);
  assign bus.rd_active   = ~(read_r[2] & read_r[1]);
  assign bus.cycle_start = cycle_start;
  assign bus.cycle_end   = cycle_end;
  assign bus.snes_dead   = snes_dead;

endmodule

/* rtl/cart_rom_ifs.sv */
`timescale 1ns/1ps
`include "cart_rom_config.svh"

////////////////////////////////////////
// Filtered SNES bus, front end to arbiter
////////////////////////////////////////

interface snes_bus_if import cart_rom_pkg::*; ();

  rom_addr_u map_addr;     // Mapped and masked ROM address
  logic      rom_hit;      // ROMSEL active
  logic      cycle_start;  // CPU clock rising
  logic      cycle_end;    // CPU clock falling
  logic      rd_active;    // Read strobe active
  logic      snes_dead;

  modport front (
    output map_addr, rom_hit, cycle_start, cycle_end, rd_active, snes_dead
  );

  modport arb (
    input map_addr, rom_hit, cycle_start, cycle_end, rd_active, snes_dead
  );

endinterface

////////////////////////////////////////
// MCU request, latch to arbiter
////////////////////////////////////////

interface mcu_rq_if import cart_rom_pkg::*; ();

  logic               rd_pend;
  logic               wr_pend;
  rom_addr_u          addr;
  logic [`BYTE_W-1:0] wr_data;
  logic               done;     // One cycle, arbiter end state

  modport req (
    output rd_pend, wr_pend, addr, wr_data,
    input  done
  );

  modport arb (
    input  rd_pend, wr_pend, addr, wr_data,
    output done
  );

endinterface

/* rtl/cart_rom_pkg.sv */
`include "cart_rom_config.svh"

package cart_rom_pkg;

  // Word view of a ROM byte address
  typedef struct packed {
    logic [`ROM_WORD_ADDR_W-1:0] word_addr;
    logic                        lo_sel;     // 1 selects the low lane
  } rom_word_t;

  // Same 24 bits, seen as a byte address or as word plus lane select
  typedef union packed {
    logic [`SNES_ADDR_W-1:0] byte_addr;
    rom_word_t               w;
  } rom_addr_u;

  // Arbiter states, one-hot
  typedef enum logic [4:0] {
    idle        = 5'b00001,
    mcu_rd_addr = 5'b00010,
    mcu_rd_end  = 5'b00100,
    mcu_wr_addr = 5'b01000,
    mcu_wr_end  = 5'b10000
  } arb_state_e;

endpackage

/* rtl/cart_rom_config.svh */
`ifndef CART_ROM_CONFIG_SVH
`define CART_ROM_CONFIG_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

`define SNES_ADDR_W      24   // SNES A-bus incl. bank
`define ROM_WORD_ADDR_W  23   // PSRAM word address
`define ROM_DATA_W       16   // PSRAM data, two byte lanes
`define BYTE_W           8

////////////////////////////////////////
// Timing
////////////////////////////////////////

// Strobe shift register length
`define SYNC_DEPTH       8
// Start value of the access delay counter, gives 8 address cycles
`define ROM_CYCLE_LEN    7
`define SNES_DEAD_TIMEOUT 96000 // About 1 ms of CPU clock low

`endif
